//--- ooo_issue_macros.svh
`ifndef OOO_ISSUE_MACROS_SVH
`define OOO_ISSUE_MACROS_SVH

// datapath widths
`define XLEN 32
`define TAG_W 6

// dispatch slots per cycle
`define WRITE_NUM 2

// execution resources
`define ALU_NUM 2
`define WAKE_NUM 3

// queue depths
`define ALU_QUEUE_LEN 8
`define MUL_QUEUE_LEN 4

// multiplier pipeline depth
`define MUL_LAT 3

`endif

//--- ooo_issue_pkg.sv
`include "ooo_issue_macros.svh"

package ooo_issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } opcode_e;

    // which queue an operation belongs to
    typedef enum logic {
        ALU = 1'b0,
        MUL = 1'b1
    } entry_type_e;

    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t data;
    } src_t;

    typedef struct packed {
        opcode_e op;
        tag_t    dst;
        src_t    src1;
        src_t    src2;
    } entry_t;

    typedef struct packed {
        logic        valid;
        entry_type_e entry_type;
        entry_t      entry;
    } write_req_t;

    typedef struct packed {
        logic   valid;
        entry_t entry;
    } read_resp_t;

    // result broadcast, doubles as wakeup
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } complete_t;

endpackage

//--- issue_queue.sv
`timescale 1ns/1ps
`include "ooo_issue_macros.svh"

module issue_queue
    import ooo_issue_pkg::*;
#(
    parameter int          QUEUE_LEN  = `ALU_QUEUE_LEN,
    parameter entry_type_e ENTRY_TYPE = ALU,
    parameter int          READ_NUM   = `ALU_NUM
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  write_req_t [`WRITE_NUM-1:0] write,
    input  complete_t  [`WAKE_NUM-1:0]  wake,
    output read_resp_t [READ_NUM-1:0]   read,
    output logic                        full
);
    localparam int CNT_W = $clog2(QUEUE_LEN + 1);

    entry_t           queue     [QUEUE_LEN];
    entry_t           queue_nxt [QUEUE_LEN];
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;

    // only a waiting source picks up a broadcast
    function automatic src_t wake_src(src_t s, complete_t [`WAKE_NUM-1:0] w);
        src_t r;
        r = s;
        for (int i = 0; i < `WAKE_NUM; i++) begin
            if (w[i].valid && !r.ready && w[i].tag == r.tag) begin
                r.ready = 1'b1;
                r.data  = w[i].data;
            end
        end
        return r;
    endfunction

    function automatic entry_t wake_entry(entry_t e, complete_t [`WAKE_NUM-1:0] w);
        entry_t r;
        r      = e;
        r.src1 = wake_src(e.src1, w);
        r.src2 = wake_src(e.src2, w);
        return r;
    endfunction

    always_comb begin
        entry_t                    cand;
        entry_t                    after_read [QUEUE_LEN];
        read_resp_t [READ_NUM-1:0] read_ar;
        int                        n_rd;
        int                        n_keep;
        int                        n_keep_ar;
        logic                      overflow;

        queue_nxt = queue;
        read      = '0;
        cand      = '0;
        n_rd      = 0;
        n_keep    = 0;
        overflow  = 1'b0;

        // oldest first select, survivors slide toward index 0
        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (i < int'(count)) begin
                cand = wake_entry(queue[i], wake);
                if (cand.src1.ready && cand.src2.ready && n_rd < READ_NUM) begin
                    read[n_rd].valid = 1'b1;
                    read[n_rd].entry = cand;
                    n_rd++;
                end else begin
                    queue_nxt[n_keep] = cand;
                    n_keep++;
                end
            end
        end

        after_read = queue_nxt;
        read_ar    = read;
        n_keep_ar  = n_keep;

        // writes in slot order, bypass to a free read slot when ready
        for (int s = 0; s < `WRITE_NUM; s++) begin
            if (write[s].valid && write[s].entry_type == ENTRY_TYPE) begin
                cand = wake_entry(write[s].entry, wake);
                if (cand.src1.ready && cand.src2.ready && n_rd < READ_NUM) begin
                    read[n_rd].valid = 1'b1;
                    read[n_rd].entry = cand;
                    n_rd++;
                end else if (n_keep < QUEUE_LEN) begin
                    queue_nxt[n_keep] = cand;
                    n_keep++;
                end else begin
                    overflow = 1'b1;
                end
            end
        end

        // no room: the whole cycle's dispatch is retried, bypasses included
        if (overflow) begin
            queue_nxt = after_read;
            read      = read_ar;
            n_keep    = n_keep_ar;
        end

        full      = overflow;
        count_nxt = CNT_W'(n_keep);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

    always_ff @(posedge clk) begin
        queue <= queue_nxt;
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(QUEUE_LEN));

    for (genvar k = 0; k < READ_NUM; k++) begin : g_read_chk
        a_read_ready: assert property (@(posedge clk) disable iff (!arst_n)
            read[k].valid |-> (read[k].entry.src1.ready && read[k].entry.src2.ready));
    end

endmodule

//--- alu_pipe.sv
`timescale 1ns/1ps
`include "ooo_issue_macros.svh"

module alu_pipe
    import ooo_issue_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  read_resp_t issue,
    output complete_t  complete
);
    localparam int SHAMT_W = $clog2(`XLEN);

    word_t              a;
    word_t              b;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;
    logic               valid_q;
    tag_t               tag_q;
    word_t              data_q;

    assign a     = issue.entry.src1.data;
    assign b     = issue.entry.src2.data;
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (issue.entry.op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q  <= issue.entry.dst;
        data_q <= result;
    end

    assign complete.valid = valid_q;
    assign complete.tag   = tag_q;
    assign complete.data  = data_q;

    // the queues route multiplies elsewhere
    a_no_mul: assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid |-> issue.entry.op != OP_MUL);

endmodule

//--- mul_pipe.sv
`timescale 1ns/1ps
`include "ooo_issue_macros.svh"

module mul_pipe
    import ooo_issue_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  read_resp_t issue,
    output complete_t  complete
);
    logic [`MUL_LAT-1:0]  vld;
    tag_t                 tag_q [`MUL_LAT];
    word_t                a_q;
    word_t                b_q;
    logic [2*`XLEN-1:0]   a_ext;
    logic [2*`XLEN-1:0]   b_ext;
    logic [2*`XLEN-1:0]   prod_q;
    word_t                data_q;

    assign a_ext = {{`XLEN{1'b0}}, a_q};
    assign b_ext = {{`XLEN{1'b0}}, b_q};

    // valid shifts alongside the data stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld <= '0;
        end else if (flush) begin
            vld <= '0;
        end else begin
            vld <= {vld[`MUL_LAT-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk) begin
        a_q      <= issue.entry.src1.data;
        b_q      <= issue.entry.src2.data;
        prod_q   <= a_ext * b_ext;
        // low word only leaves the pipe
        data_q   <= prod_q[`XLEN-1:0];
        tag_q[0] <= issue.entry.dst;
        for (int i = 1; i < `MUL_LAT; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
    end

    assign complete.valid = vld[`MUL_LAT-1];
    assign complete.tag   = tag_q[`MUL_LAT-1];
    assign complete.data  = data_q;

    a_only_mul: assert property (@(posedge clk) disable iff (!arst_n)
        issue.valid |-> issue.entry.op == OP_MUL);

endmodule

//--- ooo_issue_top.sv
`timescale 1ns/1ps
`include "ooo_issue_macros.svh"

module ooo_issue_top
    import ooo_issue_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  write_req_t [`WRITE_NUM-1:0] dispatch,
    output complete_t  [`WAKE_NUM-1:0]  complete,
    output logic                        alu_full,
    output logic                        mul_full
);
    read_resp_t [`ALU_NUM-1:0] alu_issue;
    read_resp_t [0:0]          mul_issue;

    issue_queue #(
        .QUEUE_LEN  (`ALU_QUEUE_LEN),
        .ENTRY_TYPE (ALU),
        .READ_NUM   (`ALU_NUM)
    ) u_alu_iq (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .write  (dispatch),
        .wake   (complete),
        .read   (alu_issue),
        .full   (alu_full)
    );

    issue_queue #(
        .QUEUE_LEN  (`MUL_QUEUE_LEN),
        .ENTRY_TYPE (MUL),
        .READ_NUM   (1)
    ) u_mul_iq (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .write  (dispatch),
        .wake   (complete),
        .read   (mul_issue),
        .full   (mul_full)
    );

    // wake order is alu0, alu1, mul
    alu_pipe u_alu0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .issue    (alu_issue[0]),
        .complete (complete[0])
    );

    alu_pipe u_alu1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .issue    (alu_issue[1]),
        .complete (complete[1])
    );

    mul_pipe u_mul (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .issue    (mul_issue[0]),
        .complete (complete[2])
    );

endmodule

//--- tb_ooo_issue.sv
`timescale 1ns/1ps
`include "ooo_issue_macros.svh"

module tb_ooo_issue
    import ooo_issue_pkg::*;
();
    localparam int NTAGS       = 1 << `TAG_W;
    localparam int RETRY_LIMIT = 64;
    localparam int DRAIN_LIMIT = 400;
    localparam int STALL_LIMIT = 12;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PEND = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;
    localparam logic [1:0] ST_KILL = 2'd3;

    logic                        clk;
    logic                        arst_n;
    logic                        flush;
    write_req_t [`WRITE_NUM-1:0] dispatch;
    complete_t  [`WAKE_NUM-1:0]  complete;
    logic                        alu_full;
    logic                        mul_full;

    // per tag bookkeeping
    logic [1:0] tag_state  [NTAGS];
    word_t      exp_data   [NTAGS];
    int         accept_cyc [NTAGS];
    int         done_cyc   [NTAGS];
    int         wait_on    [NTAGS][2];
    logic       fast_alu   [NTAGS];
    int         cyc = 0;
    int         mul_full_seen = 0;
    int         fd;

    ooo_issue_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .dispatch (dispatch),
        .complete (complete),
        .alu_full (alu_full),
        .mul_full (mul_full)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    task automatic monitor_completions();
        tag_t t;
        for (int i = 0; i < `WAKE_NUM; i++) begin
            if (complete[i].valid) begin
                t = complete[i].tag;
                if (tag_state[t] != ST_PEND) begin
                    abort_run($sformatf("completion at %0t for tag %0d which is not pending",
                                        $time, t));
                end
                check_value($sformatf("complete[%0d].data", i), 64'(complete[i].data),
                            64'(exp_data[t]));
                // ready alu ops finish in the next cycle
                if (fast_alu[t]) begin
                    check_value("alu latency", 64'(cyc - accept_cyc[t]), 64'd1);
                end
                tag_state[t] = ST_DONE;
                done_cyc[t]  = cyc;
            end
        end
    endtask

    // an accepted op whose operands all exist must finish in bounded time
    task automatic check_stalls();
        int   avail;
        int   src;
        logic known;
        for (int t = 0; t < NTAGS; t++) begin
            if (tag_state[t] == ST_PEND && accept_cyc[t] >= 0) begin
                avail = accept_cyc[t];
                known = 1'b1;
                for (int k = 0; k < 2; k++) begin
                    src = wait_on[t][k];
                    if (src >= 0) begin
                        if (tag_state[src] == ST_DONE) begin
                            if (done_cyc[src] > avail) begin
                                avail = done_cyc[src];
                            end
                        end else begin
                            known = 1'b0;
                        end
                    end
                end
                if (known && cyc - avail > STALL_LIMIT) begin
                    abort_run($sformatf("tag %0d never completed after its operands were ready",
                                        t));
                end
            end
        end
    endtask

    // drive on the rising edge, sample at the falling edge
    task automatic step(input write_req_t [`WRITE_NUM-1:0] req, input logic flush_req);
        @(posedge clk);
        dispatch <= req;
        flush    <= flush_req;
        @(negedge clk);
        cyc++;
        monitor_completions();
        check_stalls();
        if (mul_full) begin
            mul_full_seen++;
        end
    endtask

    task automatic check_idle_outputs();
        for (int i = 0; i < `WAKE_NUM; i++) begin
            check_value($sformatf("complete[%0d].valid", i), 64'(complete[i].valid), 64'd0);
        end
        check_value("alu_full", 64'(alu_full), 64'd0);
        check_value("mul_full", 64'(mul_full), 64'd0);
    endtask

    task automatic decode_opcode(input logic [31:0] name, output opcode_e op);
        case (name)
            32'("add"): op = OP_ADD;
            32'("sub"): op = OP_SUB;
            32'("and"): op = OP_AND;
            32'("or"):  op = OP_OR;
            32'("xor"): op = OP_XOR;
            32'("sll"): op = OP_SLL;
            32'("srl"): op = OP_SRL;
            32'("mul"): op = OP_MUL;
            default: begin
                op = OP_ADD;
                abort_run($sformatf("unknown opcode name %s in stimulus file", name));
            end
        endcase
    endtask

    task automatic read_op(output write_req_t req);
        logic [31:0] ty;
        logic [31:0] opn;
        opcode_e     op;
        int          dst;
        int          t1;
        int          r1;
        int          t2;
        int          r2;
        word_t       d1;
        word_t       d2;
        word_t       ex;
        int          got;
        got = $fscanf(fd, " %s %s %d %d %d %h %d %d %h %h",
                      ty, opn, dst, t1, r1, d1, t2, r2, d2, ex);
        if (got != 10 || dst < 1 || dst >= NTAGS) begin
            abort_run("malformed operation in stimulus file");
        end
        if (ty != 32'("alu") && ty != 32'("mul")) begin
            abort_run("operation type must be alu or mul");
        end
        if (tag_state[dst] != ST_IDLE) begin
            abort_run($sformatf("stimulus file reuses tag %0d", dst));
        end
        decode_opcode(opn, op);
        req                  = '0;
        req.valid            = 1'b1;
        req.entry_type       = (ty == 32'("mul")) ? MUL : ALU;
        req.entry.op         = op;
        req.entry.dst        = tag_t'(dst);
        req.entry.src1.ready = (r1 != 0);
        req.entry.src1.tag   = tag_t'(t1);
        req.entry.src1.data  = d1;
        req.entry.src2.ready = (r2 != 0);
        req.entry.src2.tag   = tag_t'(t2);
        req.entry.src2.data  = d2;
        tag_state[dst]  = ST_PEND;
        exp_data[dst]   = ex;
        accept_cyc[dst] = -1;
        wait_on[dst][0] = (r1 != 0) ? -1 : t1;
        wait_on[dst][1] = (r2 != 0) ? -1 : t2;
        fast_alu[dst]   = (ty == 32'("alu")) && r1 != 0 && r2 != 0;
    endtask

    // a held back op picks up results broadcast while it waited
    function automatic src_t forward_src(src_t s);
        if (!s.ready && tag_state[s.tag] == ST_DONE) begin
            s.ready = 1'b1;
            s.data  = exp_data[s.tag];
        end
        return s;
    endfunction

    // re-present the rejected slots until both queues take them
    task automatic dispatch_bundle(input write_req_t [`WRITE_NUM-1:0] bundle);
        write_req_t [`WRITE_NUM-1:0] pending;
        logic                        busy;
        logic                        q_full;
        int                          tries;
        pending = bundle;
        busy    = 1'b1;
        tries   = 0;
        while (busy) begin
            step(pending, 1'b0);
            busy = alu_full || mul_full;
            for (int s = 0; s < `WRITE_NUM; s++) begin
                q_full = (pending[s].entry_type == MUL) ? mul_full : alu_full;
                if (pending[s].valid && !q_full) begin
                    accept_cyc[pending[s].entry.dst] = cyc;
                    pending[s].valid = 1'b0;
                end
            end
            if (busy) begin
                for (int s = 0; s < `WRITE_NUM; s++) begin
                    pending[s].entry.src1 = forward_src(pending[s].entry.src1);
                    pending[s].entry.src2 = forward_src(pending[s].entry.src2);
                end
            end
            tries++;
            if (busy && tries >= RETRY_LIMIT) begin
                abort_run("dispatch was still rejected after the retry limit");
            end
        end
    endtask

    task automatic flush_all();
        step('0, 1'b1);
        for (int t = 0; t < NTAGS; t++) begin
            if (tag_state[t] == ST_PEND) begin
                tag_state[t] = ST_KILL;
            end
        end
        step('0, 1'b0);
        check_idle_outputs();
    endtask

    function automatic logic any_pending();
        for (int t = 0; t < NTAGS; t++) begin
            if (tag_state[t] == ST_PEND) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    initial begin
        logic [7:0]                  cmd;
        logic [8*128-1:0]            line;
        write_req_t [`WRITE_NUM-1:0] bundle;
        int                          n;
        int                          got;
        int                          tries;
        arst_n   = 1'b0;
        flush    = 1'b0;
        dispatch = '0;
        for (int t = 0; t < NTAGS; t++) begin
            tag_state[t]  = ST_IDLE;
            exp_data[t]   = '0;
            accept_cyc[t] = 0;
            fast_alu[t]   = 1'b0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) begin
            step('0, 1'b0);
            check_idle_outputs();
        end

        fd = $fopen("ooo_issue_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open ooo_issue_stimulus.txt");
        end
        while ($fscanf(fd, " %s", cmd) == 1) begin
            if (cmd == "#") begin
                got = $fgets(line, fd);
            end else if (cmd == "D") begin
                got = $fscanf(fd, " %d", n);
                if (got != 1 || n < 1 || n > `WRITE_NUM) begin
                    abort_run("bad slot count on a dispatch line");
                end
                bundle = '0;
                for (int s = 0; s < n; s++) begin
                    read_op(bundle[s]);
                end
                dispatch_bundle(bundle);
            end else if (cmd == "F") begin
                flush_all();
            end else if (cmd == "W") begin
                got = $fscanf(fd, " %d", n);
                if (got != 1) begin
                    abort_run("bad idle count on a wait line");
                end
                repeat (n) step('0, 1'b0);
            end else begin
                abort_run($sformatf("unknown command %s in stimulus file", cmd));
            end
        end
        $fclose(fd);

        tries = 0;
        while (any_pending()) begin
            step('0, 1'b0);
            tries++;
            if (tries >= DRAIN_LIMIT) begin
                abort_run("operations still pending after the drain limit");
            end
        end
        // window for stray completions
        repeat (10) step('0, 1'b0);
        if (mul_full_seen == 0) begin
            abort_run("mul_full was never raised");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- ooo_issue_stimulus.txt
# D n then n ops: type op dst src1_tag src1_rdy src1_data src2_tag src2_rdy src2_data expected
# data and expected in hex, tags and counts in decimal; F pulses flush; W n idles n cycles
# all alu opcodes, ready operands
D 2 alu add 1 0 1 5 0 1 3 8 alu sub 2 0 1 10 0 1 3 d
D 2 alu and 3 0 1 ff0f 0 1 0f0f 0f0f alu or 4 0 1 f000 0 1 ff f0ff
D 2 alu xor 5 0 1 aaaa 0 1 5555 ffff alu sll 6 0 1 1 0 1 24 10
D 2 alu srl 7 0 1 80000000 0 1 3f 1 alu sub 8 0 1 0 0 1 1 ffffffff
W 2
# back to back multiplies
D 2 mul mul 10 0 1 3 0 1 7 15 mul mul 11 0 1 ffff 0 1 10001 ffffffff
D 2 mul mul 12 0 1 12345678 0 1 10 23456780 mul mul 13 0 1 ffffffff 0 1 ffffffff 1
W 8
# dependent chain through both queues
D 2 mul mul 20 0 1 6 0 1 7 2a alu add 21 0 1 100 20 0 0 12a
D 2 alu sub 22 21 0 0 0 1 2 128 mul mul 23 21 0 0 0 1 3 37e
D 1 alu xor 24 22 0 0 23 0 0 256
W 10
# mul queue fills behind tag 31
D 2 mul mul 30 0 1 4 0 1 5 14 alu add 31 30 0 0 0 1 1 15
D 2 mul mul 32 31 0 0 0 1 2 2a mul mul 33 31 0 0 0 1 3 3f
D 2 mul mul 34 31 0 0 0 1 4 54 mul mul 35 31 0 0 0 1 5 69
D 2 mul mul 36 31 0 0 0 1 6 7e mul mul 37 31 0 0 0 1 7 93
W 16
# waiting entries and an in flight multiply are flushed
D 2 alu add 40 63 0 0 0 1 1 0 mul mul 41 63 0 0 0 1 2 0
D 1 mul mul 42 0 1 9 0 1 9 51
F
W 10
# tag 63 now produced, flushed waiters must stay silent
D 1 alu or 63 0 1 f0 0 1 f ff
D 2 alu add 43 63 0 0 0 1 1 100 mul mul 44 63 0 0 0 1 2 1fe
W 4

//--- ooo_issue.f
+incdir+.
ooo_issue_pkg.sv
issue_queue.sv
alu_pipe.sv
mul_pipe.sv
ooo_issue_top.sv
tb_ooo_issue.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue
FLIST     ?= ooo_issue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
